//--- simple_system_pkg.sv
package simple_system_pkg;

  // Bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int BE_W   = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Host to bus and bus to device request
  typedef struct packed {
    logic            req;
    logic            we;
    logic [BE_W-1:0] be;
    addr_t           addr;
    data_t           wdata;
  } bus_req_t;

  // Response returned one cycle after acceptance
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_SIM_CTRL,
    DEV_TIMER
  } bus_device_e;

  localparam int NR_DEVICES = 3;

  // Address map, base compared under mask
  localparam addr_t RAM_BASE      = 32'h0010_0000;
  localparam addr_t RAM_MASK      = ~32'h0000_0FFF;
  localparam addr_t SIM_CTRL_BASE = 32'h0002_0000;
  localparam addr_t SIM_CTRL_MASK = ~32'h0000_03FF;
  localparam addr_t TIMER_BASE    = 32'h0003_0000;
  localparam addr_t TIMER_MASK    = ~32'h0000_03FF;

  // 4 KB of 32-bit words
  localparam int RAM_DEPTH = 1024;
  localparam int RAM_AW    = $clog2(RAM_DEPTH);

  // Register offsets inside a 1 KB device window
  localparam int REG_OFS_W = 10;
  typedef logic [REG_OFS_W-1:0] reg_ofs_t;

  localparam reg_ofs_t SIM_CTRL_OUT_OFS      = 10'h000;
  localparam reg_ofs_t SIM_CTRL_HALT_OFS     = 10'h008;
  localparam reg_ofs_t TIMER_MTIME_LO_OFS    = 10'h000;
  localparam reg_ofs_t TIMER_MTIME_HI_OFS    = 10'h004;
  localparam reg_ofs_t TIMER_MTIMECMP_LO_OFS = 10'h008;
  localparam reg_ofs_t TIMER_MTIMECMP_HI_OFS = 10'h00C;

endpackage

//--- system_bus.sv
`timescale 1ns/1ps

module system_bus (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  simple_system_pkg::bus_req_t  host_req_i,
  output logic                         host_gnt_o,
  output simple_system_pkg::bus_rsp_t  host_rsp_o,
  output simple_system_pkg::bus_req_t  dev_req_o [simple_system_pkg::NR_DEVICES],
  input  simple_system_pkg::bus_rsp_t  dev_rsp_i [simple_system_pkg::NR_DEVICES]
);

  logic [simple_system_pkg::NR_DEVICES-1:0] dev_hit;
  simple_system_pkg::bus_device_e           dev_sel;
  logic                                     unmapped;

  simple_system_pkg::bus_device_e sel_q;
  logic                           rsp_pending_q;
  logic                           unmapped_q;

  // Single host, so no arbitration and no back-pressure
  assign host_gnt_o = host_req_i.req;

  // Address decode against the fixed map
  always_comb begin
    dev_hit = '0;
    dev_hit[simple_system_pkg::DEV_RAM] =
      (host_req_i.addr & simple_system_pkg::RAM_MASK) == simple_system_pkg::RAM_BASE;
    dev_hit[simple_system_pkg::DEV_SIM_CTRL] =
      (host_req_i.addr & simple_system_pkg::SIM_CTRL_MASK) == simple_system_pkg::SIM_CTRL_BASE;
    dev_hit[simple_system_pkg::DEV_TIMER] =
      (host_req_i.addr & simple_system_pkg::TIMER_MASK) == simple_system_pkg::TIMER_BASE;
  end

  // Windows do not overlap, the order only settles a don't-care
  always_comb begin
    dev_sel = simple_system_pkg::DEV_RAM;
    if (dev_hit[simple_system_pkg::DEV_SIM_CTRL]) begin
      dev_sel = simple_system_pkg::DEV_SIM_CTRL;
    end else if (dev_hit[simple_system_pkg::DEV_TIMER]) begin
      dev_sel = simple_system_pkg::DEV_TIMER;
    end
  end

  assign unmapped = host_req_i.req & ~(|dev_hit);

  // Every device sees the payload, only the selected one gets req
  always_comb begin
    for (int i = 0; i < simple_system_pkg::NR_DEVICES; i++) begin
      dev_req_o[i]     = host_req_i;
      dev_req_o[i].req = host_req_i.req & dev_hit[i];
    end
  end

  // Remember the target for the response cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_pending_q <= 1'b0;
      unmapped_q    <= 1'b0;
      sel_q         <= simple_system_pkg::DEV_RAM;
    end else begin
      rsp_pending_q <= host_req_i.req;
      unmapped_q    <= unmapped;
      if (host_req_i.req) begin
        sel_q <= dev_sel;
      end
    end
  end

  // Unmapped accesses are answered here with an error
  always_comb begin
    host_rsp_o = '0;
    if (rsp_pending_q) begin
      if (unmapped_q) begin
        host_rsp_o.rvalid = 1'b1;
        host_rsp_o.err    = 1'b1;
      end else begin
        host_rsp_o = dev_rsp_i[sel_q];
      end
    end
  end

endmodule

//--- ram_1p.sv
`timescale 1ns/1ps

module ram_1p (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o
);

  simple_system_pkg::data_t mem [simple_system_pkg::RAM_DEPTH];

  logic [simple_system_pkg::RAM_AW-1:0] word_addr;
  simple_system_pkg::data_t             rdata_q;
  logic                                 rvalid_q;

  // Word index inside the 4 KB window
  assign word_addr = req_i.addr[simple_system_pkg::RAM_AW+1:2];

  // Storage, read returns the old word on a write
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < simple_system_pkg::BE_W; b++) begin
          if (req_i.be[b]) begin
            mem[word_addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end
      rdata_q <= mem[word_addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  // RAM never errors
  assign rsp_o.err    = 1'b0;

endmodule

//--- sim_ctrl.sv
`timescale 1ns/1ps

module sim_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o,
  output logic                        char_valid_o,
  output logic [7:0]                  char_o,
  output logic                        halt_o
);

  simple_system_pkg::reg_ofs_t ofs;
  logic                        wr_out;
  logic                        wr_halt;
  logic                        rd_halt;

  logic                        char_valid_q;
  logic [7:0]                  char_q;
  logic                        halt_q;
  logic                        rvalid_q;
  simple_system_pkg::data_t    rdata_q;

  assign ofs     = req_i.addr[simple_system_pkg::REG_OFS_W-1:0];
  assign wr_out  = req_i.req & req_i.we & (ofs == simple_system_pkg::SIM_CTRL_OUT_OFS);
  assign wr_halt = req_i.req & req_i.we & (ofs == simple_system_pkg::SIM_CTRL_HALT_OFS);
  assign rd_halt = req_i.req & ~req_i.we & (ofs == simple_system_pkg::SIM_CTRL_HALT_OFS);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      char_valid_q <= wr_out;
      rvalid_q     <= req_i.req;
      // Sticky until reset
      if (wr_halt && req_i.wdata[0]) begin
        halt_q <= 1'b1;
      end
    end
  end

  // Character byte and read data
  always_ff @(posedge clk_i) begin
    if (wr_out) begin
      char_q <= req_i.wdata[7:0];
    end
    if (req_i.req) begin
      rdata_q <= rd_halt ? simple_system_pkg::data_t'(halt_q) : '0;
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

endmodule

//--- timer.sv
`timescale 1ns/1ps

module timer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o,
  output logic                        timer_irq_o
);

  simple_system_pkg::reg_ofs_t ofs;
  logic                        ofs_valid;
  logic                        bad_access;
  logic                        wr_ok;
  logic                        wr_mtime_lo;
  logic                        wr_mtime_hi;
  logic                        wr_cmp_lo;
  logic                        wr_cmp_hi;
  simple_system_pkg::data_t    rdata_d;

  logic [63:0]                 mtime_q;
  logic [63:0]                 mtimecmp_q;
  logic                        irq_q;
  logic                        rvalid_q;
  logic                        err_q;
  simple_system_pkg::data_t    rdata_q;

  assign ofs = req_i.addr[simple_system_pkg::REG_OFS_W-1:0];

  always_comb begin
    ofs_valid = (ofs == simple_system_pkg::TIMER_MTIME_LO_OFS)    ||
                (ofs == simple_system_pkg::TIMER_MTIME_HI_OFS)    ||
                (ofs == simple_system_pkg::TIMER_MTIMECMP_LO_OFS) ||
                (ofs == simple_system_pkg::TIMER_MTIMECMP_HI_OFS);
  end

  // Registers only take full-word writes
  assign bad_access = ~ofs_valid | (req_i.we & (req_i.be != '1));
  assign wr_ok      = req_i.req & req_i.we & ~bad_access;

  assign wr_mtime_lo = wr_ok & (ofs == simple_system_pkg::TIMER_MTIME_LO_OFS);
  assign wr_mtime_hi = wr_ok & (ofs == simple_system_pkg::TIMER_MTIME_HI_OFS);
  assign wr_cmp_lo   = wr_ok & (ofs == simple_system_pkg::TIMER_MTIMECMP_LO_OFS);
  assign wr_cmp_hi   = wr_ok & (ofs == simple_system_pkg::TIMER_MTIMECMP_HI_OFS);

  // Read mux, zero on writes and errors
  always_comb begin
    rdata_d = '0;
    if (!req_i.we && !bad_access) begin
      case (ofs)
        simple_system_pkg::TIMER_MTIME_LO_OFS:    rdata_d = mtime_q[31:0];
        simple_system_pkg::TIMER_MTIME_HI_OFS:    rdata_d = mtime_q[63:32];
        simple_system_pkg::TIMER_MTIMECMP_LO_OFS: rdata_d = mtimecmp_q[31:0];
        simple_system_pkg::TIMER_MTIMECMP_HI_OFS: rdata_d = mtimecmp_q[63:32];
        default:                                  rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      // A write replaces the count for that edge
      if (wr_mtime_lo) begin
        mtime_q[31:0] <= req_i.wdata;
      end else if (wr_mtime_hi) begin
        mtime_q[63:32] <= req_i.wdata;
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end

      if (wr_cmp_lo) begin
        mtimecmp_q[31:0] <= req_i.wdata;
      end
      if (wr_cmp_hi) begin
        mtimecmp_q[63:32] <= req_i.wdata;
      end

      irq_q    <= (mtime_q >= mtimecmp_q);
      rvalid_q <= req_i.req;
      err_q    <= req_i.req & bad_access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign timer_irq_o  = irq_q;

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;

endmodule

//--- simple_system.sv
`timescale 1ns/1ps

module simple_system (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  simple_system_pkg::bus_req_t host_req_i,
  output logic                        host_gnt_o,
  output simple_system_pkg::bus_rsp_t host_rsp_o,
  output logic                        char_valid_o,
  output logic [7:0]                  char_o,
  output logic                        halt_o,
  output logic                        timer_irq_o
);

  // Per-device request and response
  simple_system_pkg::bus_req_t dev_req [simple_system_pkg::NR_DEVICES];
  simple_system_pkg::bus_rsp_t dev_rsp [simple_system_pkg::NR_DEVICES];

  system_bus u_bus (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_req_i),
    .host_gnt_o (host_gnt_o),
    .host_rsp_o (host_rsp_o),
    .dev_req_o  (dev_req),
    .dev_rsp_i  (dev_rsp)
  );

  ram_1p u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (dev_req[simple_system_pkg::DEV_RAM]),
    .rsp_o   (dev_rsp[simple_system_pkg::DEV_RAM])
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (dev_req[simple_system_pkg::DEV_SIM_CTRL]),
    .rsp_o        (dev_rsp[simple_system_pkg::DEV_SIM_CTRL]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (dev_req[simple_system_pkg::DEV_TIMER]),
    .rsp_o       (dev_rsp[simple_system_pkg::DEV_TIMER]),
    .timer_irq_o (timer_irq_o)
  );

endmodule

//--- simple_system_asserts.sv
`timescale 1ns/1ps

module simple_system_asserts (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input simple_system_pkg::bus_req_t host_req_i,
  input logic                        host_gnt_i,
  input simple_system_pkg::bus_rsp_t host_rsp_i
);

  logic accepted;
  int   fail_count = 0;

  assign accepted = host_req_i.req & host_gnt_i;

  // Single host so grant is combinational
  gnt_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_gnt_i == host_req_i.req)
    else begin
      fail_count++;
      $error("grant differs from request");
    end

  rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accepted |=> host_rsp_i.rvalid)
    else begin
      fail_count++;
      $error("no rvalid one cycle after an accepted request");
    end

  no_spurious_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rsp_i.rvalid |-> $past(accepted))
    else begin
      fail_count++;
      $error("rvalid without a request in the previous cycle");
    end

  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rsp_i.err |-> host_rsp_i.rvalid)
    else begin
      fail_count++;
      $error("err high without rvalid");
    end

endmodule

bind system_bus simple_system_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .host_req_i (host_req_i),
  .host_gnt_i (host_gnt_o),
  .host_rsp_i (host_rsp_o)
);

//--- tb_simple_system.sv
`timescale 1ns/1ps

module tb_simple_system;

  localparam int    CLK_PERIOD  = 8;
  localparam int    DRIVE_DELAY = 1;
  localparam int    RSP_TIMEOUT = 4;
  localparam int    RAND_WRITES = 64;
  localparam int    RAND_BASE   = 256;
  localparam string INPUT_FILE  = "simple_system_input.txt";

  typedef logic [8*24-1:0] name_t;

  // One line of the stimulus file
  typedef struct packed {
    name_t                    name;
    logic [7:0]               op;
    simple_system_pkg::addr_t addr;
    logic [3:0]               be;
    simple_system_pkg::data_t wdata;
    simple_system_pkg::data_t expected;
  } test_op_t;

  logic                        clk;
  logic                        rst_n;
  simple_system_pkg::bus_req_t host_req;
  logic                        host_gnt;
  simple_system_pkg::bus_rsp_t host_rsp;
  logic                        char_valid;
  logic [7:0]                  char_byte;
  logic                        halt;
  logic                        timer_irq;

  test_op_t                 ops [$];
  bit                       ops_loaded;
  int                       char_count;
  logic [7:0]               last_char;
  integer                   seed;
  simple_system_pkg::data_t ram_model [simple_system_pkg::RAM_DEPTH];
  bit                       ram_touched [simple_system_pkg::RAM_DEPTH];
  int                       touched_idx [$];

  simple_system u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .host_req_i   (host_req),
    .host_gnt_o   (host_gnt),
    .host_rsp_o   (host_rsp),
    .char_valid_o (char_valid),
    .char_o       (char_byte),
    .halt_o       (halt),
    .timer_irq_o  (timer_irq)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Character strobes as the console would see them
  always @(posedge clk) begin
    if (rst_n && char_valid) begin
      char_count <= char_count + 1;
      last_char  <= char_byte;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  // Bound bus checker counts every failed property
  always @(negedge clk) begin
    if (u_dut.u_bus.u_asserts.fail_count != 0) begin
      abort_run("a bus protocol assertion failed");
    end
  end

  task automatic check_data(input name_t name, input simple_system_pkg::data_t expected,
                            input simple_system_pkg::data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %0s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_err(input name_t name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %0s: expected err %b, actual %b",
                          name, expected, actual));
    end
  endtask

  task automatic check_level(input name_t name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %0s: expected level %b, actual %b",
                          name, expected, actual));
    end
  endtask

  task automatic check_char(input name_t name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %0s: expected char %h, actual %h",
                          name, expected, actual));
    end
  endtask

  // Byte-lane write as the RAM should apply it
  function automatic simple_system_pkg::data_t merge_bytes(
    input simple_system_pkg::data_t old_word,
    input simple_system_pkg::data_t new_word,
    input logic [3:0]               be
  );
    simple_system_pkg::data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  // Starts and ends just after a rising edge
  task automatic bus_access(input name_t name, input logic we, input logic [3:0] be,
                            input simple_system_pkg::addr_t addr,
                            input simple_system_pkg::data_t wdata,
                            output simple_system_pkg::data_t rdata, output logic err);
    int waited;
    host_req       = '0;
    host_req.req   = 1'b1;
    host_req.we    = we;
    host_req.be    = be;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    // Single host, so the grant is up within the request cycle
    @(negedge clk);
    check_level(name, 1'b1, host_gnt);
    @(posedge clk);
    #DRIVE_DELAY;
    host_req = '0;
    waited   = 0;
    while (!host_rsp.rvalid && waited < RSP_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
    end
    if (!host_rsp.rvalid) begin
      abort_run($sformatf("%0s: no response within %0d cycles", name, RSP_TIMEOUT));
    end
    rdata = host_rsp.rdata;
    err   = host_rsp.err;
  endtask

  // Two reads on back to back request slots
  task automatic read_pair(input name_t name, input simple_system_pkg::addr_t addr,
                           output simple_system_pkg::data_t first,
                           output simple_system_pkg::data_t second);
    host_req      = '0;
    host_req.req  = 1'b1;
    host_req.addr = addr;
    @(posedge clk);
    #DRIVE_DELAY;
    if (!host_rsp.rvalid) begin
      abort_run($sformatf("%0s: first read of the pair got no response", name));
    end
    first = host_rsp.rdata;
    @(posedge clk);
    #DRIVE_DELAY;
    host_req = '0;
    if (!host_rsp.rvalid) begin
      abort_run($sformatf("%0s: second read of the pair got no response", name));
    end
    second = host_rsp.rdata;
  endtask

  task automatic load_ops();
    int                       fd;
    int                       rc;
    string                    line;
    test_op_t                 t;
    name_t                    name;
    logic [7:0]               op;
    simple_system_pkg::addr_t addr;
    logic [3:0]               be;
    simple_system_pkg::data_t wdata;
    simple_system_pkg::data_t expected;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open stimulus file %s", INPUT_FILE));
    end
    while (!$feof(fd)) begin
      line = "";
      rc   = $fgets(line, fd);
      // Skip blank lines and the column header
      if (line.len() > 1 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, be, wdata, expected);
        if (rc != 6) begin
          abort_run($sformatf("malformed stimulus line: %s", line));
        end
        t = '{name: name, op: op, addr: addr, be: be, wdata: wdata, expected: expected};
        ops.push_back(t);
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_op(input test_op_t t);
    simple_system_pkg::data_t rdata;
    simple_system_pkg::data_t rdata2;
    logic                     err;
    int                       strobes;
    case (t.op)
      "W": begin
        bus_access(t.name, 1'b1, t.be, t.addr, t.wdata, rdata, err);
        check_err(t.name, t.expected[0], err);
      end
      "R": begin
        bus_access(t.name, 1'b0, 4'h0, t.addr, '0, rdata, err);
        check_err(t.name, 1'b0, err);
        check_data(t.name, t.expected, rdata);
      end
      "E": begin
        bus_access(t.name, 1'b0, 4'h0, t.addr, '0, rdata, err);
        check_err(t.name, t.expected[0], err);
        if (t.expected[0]) begin
          check_data(t.name, '0, rdata);
        end
      end
      "I", "H": begin
        repeat (t.wdata) @(posedge clk);
        #DRIVE_DELAY;
        if (t.op == "I") begin
          check_level(t.name, t.expected[0], timer_irq);
        end else begin
          check_level(t.name, t.expected[0], halt);
        end
      end
      "C": begin
        strobes = char_count;
        bus_access(t.name, 1'b1, t.be, t.addr, t.wdata, rdata, err);
        check_err(t.name, 1'b0, err);
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        strobes = char_count - strobes;
        if (strobes != 1) begin
          abort_run($sformatf("%0s: expected one character strobe, saw %0d", t.name, strobes));
        end
        check_char(t.name, t.expected[7:0], last_char);
      end
      "T": begin
        read_pair(t.name, t.addr, rdata, rdata2);
        check_data(t.name, t.expected, rdata2 - rdata);
      end
      default: begin
        abort_run($sformatf("%0s: unknown operation %s", t.name, t.op));
      end
    endcase
  endtask

  task automatic run_random_ram();
    int                       idx;
    logic [3:0]               be;
    simple_system_pkg::data_t wdata;
    simple_system_pkg::data_t rdata;
    logic                     err;
    for (int n = 0; n < RAND_WRITES; n++) begin
      idx   = RAND_BASE + ($random(seed) & 511);
      be    = 4'($random(seed));
      wdata = $random(seed);
      // Fresh word gets all lanes so the model holds no unknown byte
      if (!ram_touched[idx]) begin
        be               = 4'hF;
        ram_touched[idx] = 1'b1;
        touched_idx.push_back(idx);
      end
      bus_access(name_t'("rand_wr"), 1'b1, be,
                 simple_system_pkg::RAM_BASE + simple_system_pkg::addr_t'(idx * 4),
                 wdata, rdata, err);
      check_err(name_t'("rand_wr"), 1'b0, err);
      ram_model[idx] = merge_bytes(ram_model[idx], wdata, be);
    end
    foreach (touched_idx[i]) begin
      bus_access(name_t'("rand_rd"), 1'b0, 4'h0,
                 simple_system_pkg::RAM_BASE + simple_system_pkg::addr_t'(touched_idx[i] * 4),
                 '0, rdata, err);
      check_data(name_t'("rand_rd"), ram_model[touched_idx[i]], rdata);
    end
  endtask

  initial begin
    host_req   = '0;
    rst_n      = 1'b0;
    char_count = 0;
    seed       = 32'h10d44690;
    load_ops();
    ops_loaded = 1'b1;
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    foreach (ops[i]) begin
      apply_op(ops[i]);
    end
    run_random_ram();
    $display("Finished with no errors");
    $finish;
  end

  // Budget of ten cycles per file line and per random access
  initial begin : watchdog
    int wd_cycles;
    wait (ops_loaded);
    wd_cycles = (ops.size() + 128) * 10;
    #(wd_cycles * CLK_PERIOD);
    $display("Timeout: the test did not complete within %0d clock cycles", wd_cycles);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- simple_system_input.txt
# name op addr be wdata expected, numbers in hex
# W checks err, E err only, I and H wait wdata cycles then check the level, T mtime step
irq_after_reset   I 00000000 0 00000003 00000000
halt_after_reset  H 00000000 0 00000002 00000000
ram_full_wr       W 00100000 f 11223344 00000000
ram_lane_wr       W 00100000 5 aabbccdd 00000000
ram_merge_rd      R 00100000 0 00000000 11bb33dd
ram_ok_err        E 00100ffc 0 00000000 00000000
unmapped_err      E 00200000 0 00000000 00000001
timer_ofs_err     E 00030010 0 00000000 00000001
timer_part_wr     W 00030008 3 00000000 00000001
char_low_byte     C 00020000 f 12345a63 00000063
mtime_step        T 00030000 0 00000000 00000001
mtime_wr          W 00030000 f 00001000 00000000
mtime_rd          R 00030000 0 00000000 00001000
cmp_hi_wr         W 0003000c f 00000000 00000000
cmp_lo_wr         W 00030008 f 00000100 00000000
irq_high          I 00000000 0 00000004 00000001
cmp_lo_max        W 00030008 f ffffffff 00000000
cmp_hi_max        W 0003000c f ffffffff 00000000
irq_low           I 00000000 0 00000004 00000000
halt_wr           W 00020008 f 00000001 00000000
halt_high         H 00000000 0 00000002 00000001
halt_rd           R 00020008 0 00000000 00000001
halt_clear_wr     W 00020008 f 00000000 00000000
halt_sticky       H 00000000 0 00000002 00000001

//--- simple_system.f
simple_system_pkg.sv
system_bus.sv
ram_1p.sv
sim_ctrl.sv
timer.sv
simple_system.sv
simple_system_asserts.sv
tb_simple_system.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run with Verilator, pass only if the pass message shows up
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f simple_system.f \
    --top-module tb_simple_system &&
  ./obj_dir/Vtb_simple_system | tee /dev/stderr | grep "Finished with no errors" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
